// ==== verilog/main_map_pkg.sv ====
/* Main CPU memory map definitions */

`default_nettype none

package main_map_pkg;

    // Decoded target of a main CPU access
    typedef enum logic [2:0] {
        reg_none,
        reg_rom,
        reg_vram,
        reg_ram,
        reg_vctrl,
        reg_vflag,  // Write only
        reg_bank,   // Write only
        reg_pal
    } region_e;

    // Current owner of the shared RAM
    typedef enum logic [1:0] {
        arb_idle,
        arb_main,
        arb_sub
    } arb_state_e;

    // ROM bank latch width
    localparam int bank_w = 3;

    // Byte address into the program ROM
    localparam int rom_aw = 17;

endpackage

`default_nettype wire

// ==== verilog/main_decode.sv ====
/* Main CPU address decoder */

`default_nettype none

module main_decode (
    input  wire                   clk,
    input  wire                   rst,
    input  wire  [15:0]           cpu_addr,
    input  wire  [7:0]            cpu_wdata,
    input  wire                   mreq,
    input  wire                   rfsh,
    input  wire                   wr,
    output main_map_pkg::region_e sel_region,
    output logic [15:0]           acc_addr,
    output logic [7:0]            acc_wdata,
    output logic                  acc_wr,
    output logic                  rom_cs,
    output logic                  vram_cs,
    output logic                  ram_cs,
    output logic                  vctrl_cs,
    output logic                  vflag_cs,
    output logic                  bank_cs,
    output logic                  pal_cs,
    output logic                  obj_vram_en
);
    import main_map_pkg::*;

    logic    mem_acc;
    logic    hit_rom;
    logic    hit_vram;
    logic    hit_ram;
    logic    hit_vctrl;
    logic    hit_vflag;
    logic    hit_bank;
    logic    hit_pal;
    logic    hit_obj;
    region_e region_nx;

    assign mem_acc   = mreq & ~rfsh;  // Refresh cycles are not accesses
    assign hit_rom   = mem_acc && cpu_addr[15:12] < 4'hc;
    assign hit_vram  = mem_acc && cpu_addr[15:13] == 3'b110;     // c000-dfff
    assign hit_ram   = mem_acc && cpu_addr[15:12] == 4'he;
    assign hit_vctrl = mem_acc && cpu_addr[15:10] == 6'b111100;  // f000-f3ff
    assign hit_vflag = mem_acc && cpu_addr[15:9] == 7'b1111010 && wr;
    assign hit_bank  = mem_acc && cpu_addr[15:9] == 7'b1111011 && wr;
    assign hit_pal   = mem_acc && cpu_addr[15:11] == 5'h1f;

    // Object tables share the video timing slot with VRAM
    assign hit_obj = hit_vram || hit_vctrl ||
                     (mem_acc && cpu_addr[15:11] == 5'b11110 && !cpu_addr[9]);

    // Same order as the read data mux
    always_comb begin
        if (hit_rom)                    region_nx = reg_rom;
        else if (hit_ram)               region_nx = reg_ram;
        else if (hit_vram)              region_nx = reg_vram;
        else if (hit_vctrl)             region_nx = reg_vctrl;
        else if (hit_pal)               region_nx = reg_pal;
        else if (hit_vflag)             region_nx = reg_vflag;
        else if (hit_bank)              region_nx = reg_bank;
        else                            region_nx = reg_none;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_region  <= reg_none;
            acc_wr      <= 1'b0;
            rom_cs      <= 1'b0;
            vram_cs     <= 1'b0;
            ram_cs      <= 1'b0;
            vctrl_cs    <= 1'b0;
            vflag_cs    <= 1'b0;
            bank_cs     <= 1'b0;
            pal_cs      <= 1'b0;
            obj_vram_en <= 1'b0;
        end else begin
            sel_region  <= region_nx;
            acc_wr      <= mem_acc & wr;
            rom_cs      <= hit_rom;
            vram_cs     <= hit_vram;
            ram_cs      <= hit_ram;
            vctrl_cs    <= hit_vctrl;
            vflag_cs    <= hit_vflag;
            bank_cs     <= hit_bank;
            pal_cs      <= hit_pal;
            obj_vram_en <= hit_obj;
        end
    end

    always_ff @(posedge clk) begin
        acc_addr  <= cpu_addr;
        acc_wdata <= cpu_wdata;
    end

    // Flag and bank registers only ever see write cycles
    a_wo_regions: assert property (@(posedge clk) disable iff (rst)
        (vflag_cs || bank_cs) |-> $past(mreq && wr));

endmodule

`default_nettype wire

// ==== verilog/rom_banker.sv ====
/* ROM bank latch */

`default_nettype none

module rom_banker (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              bank_cs,
    input  wire  [15:0]                      acc_addr,
    input  wire  [7:0]                       acc_wdata,
    output logic [main_map_pkg::rom_aw-1:0]  rom_addr,
    output logic                             snd_rstn
);
    import main_map_pkg::*;

    logic [bank_w-1:0] bank;

    // Bank number and sound CPU reset share one write register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            snd_rstn <= 1'b0;  // Sound CPU held until the game releases it
        end else if (bank_cs) begin
            bank     <= acc_wdata[bank_w-1:0];
            snd_rstn <= acc_wdata[4];
        end
    end

    // 0000-7fff maps straight to the first two 16kB pages
    // 8000-bfff looks into the page picked by the bank
    always_comb begin
        if (acc_addr[15])
            rom_addr = {bank, acc_addr[13:0]};
        else
            rom_addr = {{(bank_w-1){1'b0}}, acc_addr[14], acc_addr[13:0]};
    end

endmodule

`default_nettype wire

// ==== verilog/shared_ram_arbiter.sv ====
/* Shared RAM arbiter */

`default_nettype none

module shared_ram_arbiter #(
    parameter int ram_aw = 13
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               ram_cs,
    input  wire  [15:0]       acc_addr,
    input  wire  [7:0]        acc_wdata,
    input  wire               acc_wr,
    input  wire               shr_cs,
    input  wire  [ram_aw-1:0] shr_addr,
    input  wire  [7:0]        shr_din,
    input  wire               sub_wr,
    output logic [7:0]        q0,
    output logic [7:0]        shr_dout,
    output logic              main_grant,
    output logic              sub_grant
);
    import main_map_pkg::*;

    arb_state_e  state;
    arb_state_e  state_nx;
    logic [7:0]  mem [2**ram_aw];
    logic [ram_aw-1:0] main_addr;
    logic        main_we;
    logic        sub_we;

    // First come, first served
    always_comb begin
        state_nx = state;
        case (state)
            arb_idle: begin
                if (ram_cs)
                    state_nx = arb_main;  // Main wins a tie
                else if (shr_cs)
                    state_nx = arb_sub;
            end
            arb_main: if (!ram_cs) state_nx = arb_idle;
            arb_sub:  if (!shr_cs) state_nx = arb_idle;
            default:  state_nx = arb_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= arb_idle;
        else
            state <= state_nx;
    end

    assign main_grant = state == arb_main;
    assign sub_grant  = state == arb_sub;

    assign main_addr = acc_addr[ram_aw-1:0];
    assign main_we   = main_grant & ram_cs & acc_wr;  // Only the owner writes
    assign sub_we    = sub_grant & shr_cs & sub_wr;

    // Both ports read every cycle
    always_ff @(posedge clk) begin
        if (main_we)
            mem[main_addr] <= acc_wdata;
        if (sub_we)
            mem[shr_addr] <= shr_din;
        q0       <= mem[main_addr];
        shr_dout <= mem[shr_addr];
    end

    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        !(main_grant && sub_grant));

endmodule

`default_nettype wire

// ==== verilog/bus_return.sv ====
/* CPU read data and wait */

`default_nettype none

module bus_return (
    input  wire                   clk,
    input  wire                   rst,
    input  main_map_pkg::region_e sel_region,
    input  wire  [7:0]            rom_data,
    input  wire  [7:0]            q0,
    input  wire  [7:0]            vram_dout,
    input  wire  [7:0]            pal_dout,
    input  wire                   sub_grant,
    input  wire                   ram_cs,
    input  wire                   obj_vram_en,
    input  wire  [8:0]            hcnt,
    output logic [7:0]            cpu_din,
    output logic                  wait_req
);
    import main_map_pkg::*;

    logic [7:0] din_nx;
    logic       ram_busy;
    logic       vid_busy;

    always_comb begin
        case (sel_region)
            reg_rom:   din_nx = rom_data;
            reg_ram:   din_nx = q0;
            reg_vram,
            reg_vctrl: din_nx = vram_dout;  // Video control reads come back on the VRAM bus
            reg_pal:   din_nx = pal_dout;
            default:   din_nx = 8'h00;      // Unmapped and write-only regions
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cpu_din <= 8'h00;
        else
            cpu_din <= din_nx;
    end

    // Sub CPU owns the shared RAM
    assign ram_busy = sub_grant & ram_cs;

    // Video chips give the CPU one slot in four pixels
    assign vid_busy = obj_vram_en && hcnt[1:0] != 2'd3;

    assign wait_req = ram_busy | vid_busy;

endmodule

`default_nettype wire

// ==== verilog/vblank_irq.sv ====
/* Vertical blank interrupt */

`default_nettype none

module vblank_irq (
    input  wire  clk,
    input  wire  rst,
    input  wire  LVBL,
    input  wire  iorq,
    output logic int_n
);

    logic lvbl_l;
    logic vb_start;

    // LVBL is low during blanking, so its falling edge starts the frame gap
    assign vb_start = lvbl_l & ~LVBL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            lvbl_l <= 1'b0;  // No edge seen straight out of reset
        else
            lvbl_l <= LVBL;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            int_n <= 1'b1;
        end else begin
            if (iorq)
                int_n <= 1'b1;  // Acknowledge beats a new request
            else if (vb_start)
                int_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/main_bus.sv ====
/* Main CPU memory map and bus glue */

`default_nettype none

module main_bus #(
    parameter int ram_aw = 13
) (
    input  wire                             clk,
    input  wire                             rst,
    // CPU
    input  wire [15:0]                      cpu_addr,
    input  wire [7:0]                       cpu_wdata,
    input  wire                             mreq,
    input  wire                             rfsh,
    input  wire                             wr,
    input  wire                             iorq,
    output wire [7:0]                       cpu_din,
    output wire                             wait_req,
    output wire                             int_n,
    output wire                             cpu_rnw,
    // Video devices
    output wire                             vram_cs,
    output wire                             vctrl_cs,
    output wire                             vflag_cs,
    output wire                             pal_cs,
    input  wire [7:0]                       pal_dout,
    input  wire [7:0]                       vram_dout,
    input  wire [8:0]                       hcnt,
    input  wire                             LVBL,
    // ROM
    output wire [main_map_pkg::rom_aw-1:0]  rom_addr,
    output wire                             rom_cs,
    input  wire [7:0]                       rom_data,
    // Sound and sub CPU
    output wire                             snd_rstn,
    input  wire                             shr_cs,
    input  wire [ram_aw-1:0]                shr_addr,
    input  wire [7:0]                       shr_din,
    input  wire                             sub_wr,
    output wire [7:0]                       shr_dout,
    output wire                             sub_grant,
    output wire                             main_grant
);
    import main_map_pkg::*;

    region_e    sel_region;
    wire [15:0] acc_addr;
    wire [7:0]  acc_wdata;
    wire        acc_wr;
    wire        ram_cs;
    wire        bank_cs;
    wire        obj_vram_en;
    wire [7:0]  q0;

    assign cpu_rnw = ~wr;

    main_decode u_decode (
        .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .mreq(mreq), .rfsh(rfsh), .wr(wr), .sel_region(sel_region),
        .acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_wr(acc_wr),
        .rom_cs(rom_cs), .vram_cs(vram_cs), .ram_cs(ram_cs), .vctrl_cs(vctrl_cs),
        .vflag_cs(vflag_cs), .bank_cs(bank_cs), .pal_cs(pal_cs),
        .obj_vram_en(obj_vram_en)
    );

    rom_banker u_banker (
        .clk(clk), .rst(rst), .bank_cs(bank_cs), .acc_addr(acc_addr),
        .acc_wdata(acc_wdata), .rom_addr(rom_addr), .snd_rstn(snd_rstn)
    );

    shared_ram_arbiter #(.ram_aw(ram_aw)) u_shram (
        .clk(clk), .rst(rst), .ram_cs(ram_cs), .acc_addr(acc_addr),
        .acc_wdata(acc_wdata), .acc_wr(acc_wr), .shr_cs(shr_cs),
        .shr_addr(shr_addr), .shr_din(shr_din), .sub_wr(sub_wr), .q0(q0),
        .shr_dout(shr_dout), .main_grant(main_grant), .sub_grant(sub_grant)
    );

    bus_return u_return (
        .clk(clk), .rst(rst), .sel_region(sel_region), .rom_data(rom_data),
        .q0(q0), .vram_dout(vram_dout), .pal_dout(pal_dout),
        .sub_grant(sub_grant), .ram_cs(ram_cs), .obj_vram_en(obj_vram_en),
        .hcnt(hcnt), .cpu_din(cpu_din), .wait_req(wait_req)
    );

    vblank_irq u_irq (
        .clk(clk), .rst(rst), .LVBL(LVBL), .iorq(iorq), .int_n(int_n)
    );

endmodule

`default_nettype wire

// ==== tests/main_bus_tb.sv ====
/* Main bus testbench */

`default_nettype none

module main_bus_tb;
    import main_map_pkg::*;

    localparam int ram_aw   = 13;
    localparam int op_rd    = 0;
    localparam int op_wr    = 1;
    localparam int op_rfsh  = 2;
    localparam int chk_none = 0;
    localparam int chk_din  = 1;
    localparam int chk_rom  = 2;  // rom_addr and the ROM byte behind it
    localparam int chk_snd  = 3;
    localparam int chk_sub  = 4;  // Sub CPU read port

    logic              clk = 1'b0;
    logic              rst;
    logic [15:0]       cpu_addr;
    logic [7:0]        cpu_wdata;
    logic              mreq, rfsh, wr, iorq, LVBL;
    logic [8:0]        hcnt;
    logic [7:0]        pal_dout, vram_dout, rom_data;
    logic              shr_cs, sub_wr;
    logic [ram_aw-1:0] shr_addr;
    logic [7:0]        shr_din, shr_dout, cpu_din;
    logic              wait_req, int_n, cpu_rnw, rom_cs;
    logic              vram_cs, vctrl_cs, vflag_cs, pal_cs;
    logic              snd_rstn, sub_grant, main_grant;
    logic [rom_aw-1:0] rom_addr;

    string             row_name  [0:31];
    logic [15:0]       row_addr  [0:31];
    int                row_op    [0:31];
    logic [7:0]        row_wdata [0:31];
    logic              row_hold  [0:31];  // Sub CPU keeps its select up
    logic [ram_aw-1:0] row_saddr [0:31];
    logic [6:0]        row_sel   [0:31];  // rom vram ram vctrl vflag bank pal
    int                row_chk   [0:31];
    logic [16:0]       row_exp   [0:31];

    int          n_rows = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    int          hbit;
    string       cur_name = "reset";
    logic [31:0] lfsr = 32'head3;

    main_bus #(.ram_aw(ram_aw)) uut (.*);

    function automatic logic [7:0] rom_byte(input logic [16:0] a);
        return a[7:0] ^ a[15:8] ^ {a[16], 7'h35};
    endfunction

    function automatic logic [7:0] vram_byte(input logic [15:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;
    endfunction

    function automatic logic [7:0] pal_byte(input logic [15:0] a);
        return ~(a[7:0] + a[15:8]);
    endfunction

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign rom_data  = rom_byte(rom_addr);
    assign vram_dout = vram_byte(cpu_addr);
    assign pal_dout  = pal_byte(cpu_addr);

    always #4 clk = ~clk;

    // Pseudo random beam position
    always @(posedge clk) begin
        #1;
        for (hbit = 0; hbit < 9; hbit++) begin
            lfsr       = lfsr_step(lfsr);
            hcnt[hbit] = lfsr[0];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run still busy after %0d clocks", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic add_row(input string name, input logic [15:0] addr, input int op,
                           input logic [7:0] wdata, input logic hold,
                           input logic [ram_aw-1:0] saddr, input logic [6:0] sel,
                           input int chk, input logic [16:0] exp);
        row_name[n_rows]  = name;
        row_addr[n_rows]  = addr;
        row_op[n_rows]    = op;
        row_wdata[n_rows] = wdata;
        row_hold[n_rows]  = hold;
        row_saddr[n_rows] = saddr;
        row_sel[n_rows]   = sel;
        row_chk[n_rows]   = chk;
        row_exp[n_rows]   = exp;
        n_rows++;
    endtask

    task automatic apply_row(input int i);
        cur_name  = row_name[i];
        cpu_addr  = row_addr[i];
        cpu_wdata = row_wdata[i];
        mreq      = 1'b1;
        rfsh      = row_op[i] == op_rfsh;
        wr        = row_op[i] == op_wr;
        shr_cs    = row_hold[i];
        shr_addr  = row_saddr[i];
    endtask

    task automatic expect_eq(input string what, input logic [16:0] exp,
                             input logic [16:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic verify_row(input int i);
        logic [6:0] sel;
        logic       ram_sel;
        sel = {rom_cs, vram_cs, uut.u_decode.ram_cs, vctrl_cs, vflag_cs,
               uut.u_decode.bank_cs, pal_cs};
        ram_sel = row_sel[i][4];
        expect_eq("selects", row_sel[i], sel);
        expect_eq("cpu_rnw", row_op[i] != op_wr, cpu_rnw);
        if (row_hold[i]) begin
            checks++;
            assert (sub_grant === 1'b1 && main_grant === 1'b0) else begin
                errors++;
                $display("%s: sub CPU does not own the shared RAM (arbiter in %s)",
                         cur_name, uut.u_shram.state.name());
            end
            if (ram_sel)
                expect_eq("wait_req", 1, wait_req);  // Main must hold off
        end else begin
            expect_eq("main_grant", ram_sel, main_grant);
            if (ram_sel)
                expect_eq("wait_req", 0, wait_req);
        end
        // VRAM side only answers in the last pixel of four
        if (row_sel[i][5] || row_sel[i][3])
            expect_eq("wait_req", hcnt[1:0] != 2'd3, wait_req);
        case (row_chk[i])
            chk_din: expect_eq("cpu_din", row_exp[i][7:0], cpu_din);
            chk_rom: begin
                expect_eq("rom_addr", row_exp[i], rom_addr);
                expect_eq("cpu_din", rom_byte(row_exp[i]), cpu_din);
            end
            chk_snd: expect_eq("snd_rstn", row_exp[i][0], snd_rstn);
            chk_sub: expect_eq("shr_dout", row_exp[i][7:0], shr_dout);
            default: ;
        endcase
    endtask

    initial begin
        rst = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        mreq = 1'b0;
        rfsh = 1'b0;
        wr = 1'b0;
        iorq = 1'b0;
        LVBL = 1'b1;
        hcnt = '0;
        shr_cs = 1'b0;
        shr_addr = '0;
        shr_din = '0;
        sub_wr = 1'b0;

        add_row("rom low", 16'h1234, op_rd, 8'h00, 0, 0, 7'b1000000, chk_rom, 17'h01234);
        add_row("rom page 1", 16'h5678, op_rd, 8'h00, 0, 0, 7'b1000000, chk_rom, 17'h05678);
        add_row("rom bank 0", 16'h9abc, op_rd, 8'h00, 0, 0, 7'b1000000, chk_rom, 17'h01abc);
        add_row("bank write 5", 16'hf600, op_wr, 8'h15, 0, 0, 7'b0000010, chk_snd, 1);
        add_row("rom bank 5", 16'h9234, op_rd, 8'h00, 0, 0, 7'b1000000, chk_rom, 17'h15234);
        add_row("rom fixed", 16'h4321, op_rd, 8'h00, 0, 0, 7'b1000000, chk_rom, 17'h04321);
        add_row("bank write 2", 16'hf7ff, op_wr, 8'h02, 0, 0, 7'b0000010, chk_snd, 0);
        add_row("rom bank 2", 16'hbfff, op_rd, 8'h00, 0, 0, 7'b1000000, chk_rom, 17'h0bfff);
        add_row("vram", 16'hc123, op_rd, 8'h00, 0, 0, 7'b0100000, chk_din, vram_byte(16'hc123));
        add_row("vram top", 16'hdfff, op_rd, 8'h00, 0, 0, 7'b0100000, chk_din, vram_byte(16'hdfff));
        add_row("vctrl", 16'hf0a5, op_rd, 8'h00, 0, 0, 7'b0001000, chk_din, vram_byte(16'hf0a5));
        add_row("flag write", 16'hf455, op_wr, 8'h01, 0, 0, 7'b0000100, chk_none, 0);
        add_row("flag read", 16'hf455, op_rd, 8'h00, 0, 0, 7'b0000000, chk_din, 0);
        add_row("bank read", 16'hf6aa, op_rd, 8'h00, 0, 0, 7'b0000000, chk_din, 0);
        add_row("palette", 16'hf812, op_rd, 8'h00, 0, 0, 7'b0000001, chk_din, pal_byte(16'hf812));
        add_row("palette top", 16'hffff, op_rd, 8'h00, 0, 0, 7'b0000001, chk_din, pal_byte(16'hffff));
        add_row("palette write", 16'hf900, op_wr, 8'h77, 0, 0, 7'b0000001, chk_none, 0);
        add_row("refresh", 16'h1234, op_rfsh, 8'h00, 0, 0, 7'b0000000, chk_din, 0);
        add_row("ram write a", 16'he123, op_wr, 8'h5a, 0, 0, 7'b0010000, chk_none, 0);
        add_row("ram read a", 16'he123, op_rd, 8'h00, 0, 0, 7'b0010000, chk_din, 8'h5a);
        add_row("ram write b", 16'he456, op_wr, 8'hc3, 0, 0, 7'b0010000, chk_none, 0);
        add_row("sub read a", 16'h0100, op_rd, 8'h00, 1, 'h123, 7'b1000000, chk_sub, 8'h5a);
        add_row("ram blocked", 16'he123, op_wr, 8'hff, 1, 'h456, 7'b0010000, chk_sub, 8'hc3);
        add_row("ram kept", 16'he123, op_rd, 8'h00, 0, 0, 7'b0010000, chk_din, 8'h5a);
        add_row("ram read b", 16'he456, op_rd, 8'h00, 0, 0, 7'b0010000, chk_din, 8'hc3);
        add_row("ram rewrite", 16'he123, op_wr, 8'h3c, 0, 0, 7'b0010000, chk_none, 0);
        add_row("ram reread", 16'he123, op_rd, 8'h00, 0, 0, 7'b0010000, chk_din, 8'h3c);
        limit = n_rows * 6 + 50;

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        expect_eq("snd_rstn", 0, snd_rstn);
        expect_eq("int_n", 1, int_n);
        expect_eq("grants", 0, {main_grant, sub_grant});

        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #1 apply_row(i);
            for (int c = 1; c <= 6; c++) begin
                @(negedge clk);
                if (c >= 4)
                    verify_row(i);  // From the 3rd clock after the address
            end
        end

        @(posedge clk);
        #1;
        cur_name = "vblank irq";
        mreq = 1'b0;
        shr_cs = 1'b0;
        expect_eq("int_n idle", 1, int_n);
        LVBL = 1'b0;
        repeat (2) @(negedge clk);
        expect_eq("int_n set", 0, int_n);
        repeat (2) @(negedge clk);
        expect_eq("int_n held", 0, int_n);
        @(posedge clk);
        #1 iorq = 1'b1;
        repeat (2) @(negedge clk);
        expect_eq("int_n ack", 1, int_n);
        @(posedge clk);
        #1;
        iorq = 1'b0;
        LVBL = 1'b1;
        repeat (3) @(negedge clk);
        expect_eq("int_n blank end", 1, int_n);  // Rising LVBL raises nothing

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/main_map_pkg.sv
verilog/main_decode.sv
verilog/rom_banker.sv
verilog/shared_ram_arbiter.sv
verilog/bus_return.sv
verilog/vblank_irq.sv
verilog/main_bus.sv
tests/main_bus_tb.sv

// ==== Bender.yml ====
package:
  name: main_bus

sources:
  - verilog/main_map_pkg.sv
  - verilog/main_decode.sv
  - verilog/rom_banker.sv
  - verilog/shared_ram_arbiter.sv
  - verilog/bus_return.sv
  - verilog/vblank_irq.sv
  - verilog/main_bus.sv
  - target: test
    files:
      - tests/main_bus_tb.sv
